// ==== flist.f ====
+incdir+design
design/il1_pkg.sv
design/il1_sram.sv
design/il1_tag_array.sv
design/il1_data_array.sv
design/il1_replace.sv
design/il1_controller.sv
design/il1_cache_top.sv
sim/il1_mem_model.sv
sim/il1_tb.sv

// ==== sim/il1_tb.sv ====
//==========================================================================
// IL1 cache testbench
// Drives fetches and invalidates against a 2-way LRU reference model,
// with a random-delay backing memory, and checks by assertions
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "il1_config.svh"

module il1_tb;

	localparam logic [31:0] LFSR_SEED  = 32'h092c9767;
	localparam logic [31:0] WORD_MULT  = 32'h9e3779b1;
	localparam int          WAIT_LIMIT = 200;

	logic           cache_clk;
	logic           rst_n;
	logic           fetch_req;
	il1_pkg::addr_t pc;
	logic           fetch_ack;
	il1_pkg::word_t inst;
	logic           inv_req;
	il1_pkg::addr_t inv_addr;
	logic           inv_ack;
	logic           mem_req;
	il1_pkg::addr_t mem_addr;
	logic           mem_ack;
	il1_pkg::word_t mem_rdata;

	// Reference model of the cache contents
	logic [23:0] model_tag [`IL1_SETS][`IL1_WAYS];
	logic        model_valid [`IL1_SETS][`IL1_WAYS];
	logic        model_lru [`IL1_SETS];

	logic [31:0]    lfsr_state = LFSR_SEED;
	il1_pkg::addr_t cur_pc = '0;
	logic           expect_hit = 1'b0;
	logic           fetch_req_q = 1'b0;
	int             mem_count = 0;
	int             value_errors = 0;
	int             protocol_errors = 0;
	string          test_name = "reset";

	il1_cache_top il1_cache_top_inst (
		.cache_clk (cache_clk),
		.rst_n     (rst_n),
		.fetch_req (fetch_req),
		.pc        (pc),
		.fetch_ack (fetch_ack),
		.inst      (inst),
		.inv_req   (inv_req),
		.inv_addr  (inv_addr),
		.inv_ack   (inv_ack),
		.mem_req   (mem_req),
		.mem_addr  (mem_addr),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata)
	);

	il1_mem_model #(
		.SEED      (LFSR_SEED),
		.DATA_MULT (WORD_MULT)
	) il1_mem_model_inst (
		.cache_clk (cache_clk),
		.rst_n     (rst_n),
		.mem_req   (mem_req),
		.mem_addr  (mem_addr),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata)
	);

	initial
	begin
		cache_clk = 1'b0;
		forever #4 cache_clk = ~cache_clk;
	end

	//======================================================================
	// Helpers
	//======================================================================

	function automatic logic [7:0] lfsr_bits(input int n);
		logic [7:0] bits;
		logic       fb;
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			bits = {bits[6:0], fb};
		end
		return bits;
	endfunction

	// Memory rule: word-aligned address times the odd constant
	function automatic il1_pkg::word_t mem_word(input il1_pkg::addr_t a);
		return {a[31:2], 2'b00} * WORD_MULT;
	endfunction

	function automatic il1_pkg::addr_t line_base(input il1_pkg::addr_t a);
		return {a[31:4], 4'h0};
	endfunction

	// Hit or miss by the model, then fill and LRU update
	function automatic logic predict_fetch(input il1_pkg::addr_t a);
		logic [3:0]  idx;
		logic [23:0] tag;
		logic        hit;
		logic        way;
		idx = a[7:4];
		tag = a[31:8];
		hit = 1'b0;
		way = 1'b0;
		for (int w = 0; w < `IL1_WAYS; w++)
			if (model_valid[idx][w] && model_tag[idx][w] == tag)
			begin
				hit = 1'b1;
				way = 1'(w);
			end
		if (!hit)
		begin
			if (!model_valid[idx][0])
				way = 1'b0;
			else if (!model_valid[idx][1])
				way = 1'b1;
			else
				way = model_lru[idx];
			model_valid[idx][way] = 1'b1;
			model_tag[idx][way]   = tag;
		end
		model_lru[idx] = ~way;
		return hit;
	endfunction

	function automatic void drop_line(input il1_pkg::addr_t a);
		for (int w = 0; w < `IL1_WAYS; w++)
			if (model_valid[a[7:4]][w] && model_tag[a[7:4]][w] == a[31:8])
				model_valid[a[7:4]][w] = 1'b0;
	endfunction

	task automatic report_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		value_errors++;
		$display("Error: %s %s expected %h actual %h", test_name, what, expected, actual);
	endtask

	task automatic report_protocol(input string what);
		protocol_errors++;
		$display("Protocol failure in %s: %s", test_name, what);
	endtask

	task automatic fail_on_timeout(input string what);
		$display("Timeout in %s: %s never reached the awaited level", test_name, what);
		$display("Summary: %0d value errors, %0d protocol errors", value_errors,
			protocol_errors);
		$display("Test failures found");
		$finish;
	endtask

	task automatic step_cycle();
		@(posedge cache_clk);
		#1;
	endtask

	task automatic wait_fetch_ack(input logic level);
		int cycles;
		cycles = 0;
		do
		begin
			step_cycle();
			cycles++;
		end while (fetch_ack !== level && cycles < WAIT_LIMIT);
		if (fetch_ack !== level)
			fail_on_timeout("fetch_ack");
	endtask

	task automatic wait_inv_ack(input logic level);
		int cycles;
		cycles = 0;
		do
		begin
			step_cycle();
			cycles++;
		end while (inv_ack !== level && cycles < WAIT_LIMIT);
		if (inv_ack !== level)
			fail_on_timeout("inv_ack");
	endtask

	// Core side, holds fetch_req a random time after the ack
	task automatic run_fetch(input il1_pkg::addr_t a, input string name);
		test_name  = name;
		cur_pc     = a;
		expect_hit = predict_fetch(a);
		pc         = a;
		fetch_req  = 1'b1;
		wait_fetch_ack(1'b1);
		repeat (lfsr_bits(2)) step_cycle();
		fetch_req = 1'b0;
		wait_fetch_ack(1'b0);
	endtask

	task automatic run_invalidate(input il1_pkg::addr_t a, input string name);
		test_name = name;
		drop_line(a);
		inv_addr = a;
		inv_req  = 1'b1;
		wait_inv_ack(1'b1);
		repeat (lfsr_bits(2)) step_cycle();
		inv_req = 1'b0;
		wait_inv_ack(1'b0);
	endtask

	// Refill handshakes seen since the fetch started
	always @(posedge cache_clk)
	begin
		fetch_req_q <= fetch_req;
		if (fetch_req && !fetch_req_q)
			mem_count <= 0;
		else if (mem_req && mem_ack)
			mem_count <= mem_count + 1;
	end

	//======================================================================
	// Checks
	//======================================================================

	reset_outputs_a: assert property (@(posedge cache_clk)
		$rose(rst_n) |-> !fetch_ack && !inv_ack && !mem_req)
		else report_protocol("an ack or mem_req was high right after reset");

	inst_value_a: assert property (@(posedge cache_clk) disable iff (!rst_n)
		$rose(fetch_ack) |-> inst == mem_word(cur_pc))
		else report_value("inst", mem_word($sampled(cur_pc)), $sampled(inst));

	hit_miss_a: assert property (@(posedge cache_clk) disable iff (!rst_n)
		$rose(fetch_ack) |-> mem_count == (expect_hit ? 0 : 4))
		else report_value("refill count", $sampled(expect_hit) ? 0 : 4, $sampled(mem_count));

	mem_addr_a: assert property (@(posedge cache_clk) disable iff (!rst_n)
		mem_req && mem_ack |-> mem_addr == line_base(cur_pc) + 32'(mem_count) * 4)
		else report_value("mem_addr", line_base($sampled(cur_pc)) + 32'($sampled(mem_count)) * 4,
			$sampled(mem_addr));

	hit_latency_a: assert property (@(posedge cache_clk) disable iff (!rst_n)
		$rose(fetch_req) && expect_hit |-> ##2 $rose(fetch_ack))
		else report_protocol("fetch_ack did not rise 2 cycles after a hit request");

	inv_latency_a: assert property (@(posedge cache_clk) disable iff (!rst_n)
		$rose(inv_req) |-> ##2 $rose(inv_ack))
		else report_protocol("inv_ack did not rise 2 cycles after the request");

	fetch_hold_a: assert property (@(posedge cache_clk) disable iff (!rst_n)
		fetch_req && fetch_ack |=> fetch_ack && $stable(inst))
		else report_protocol("fetch_ack or inst changed while fetch_req was high");

	fetch_drop_a: assert property (@(posedge cache_clk) disable iff (!rst_n)
		!fetch_req && fetch_ack |=> !fetch_ack)
		else report_protocol("fetch_ack stayed high after fetch_req fell");

	inv_order_a: assert property (@(posedge cache_clk) disable iff (!rst_n)
		inv_ack |=> (inv_ack == $past(inv_req)))
		else report_protocol("inv_ack did not follow the four-phase order");

	mem_hold_a: assert property (@(posedge cache_clk) disable iff (!rst_n)
		mem_req && !mem_ack |=> mem_req && $stable(mem_addr))
		else report_protocol("mem_req or mem_addr changed before mem_ack rose");

	mem_drop_a: assert property (@(posedge cache_clk) disable iff (!rst_n)
		mem_req && mem_ack |=> !mem_req)
		else report_protocol("mem_req stayed high after the word was taken");

	mem_restart_a: assert property (@(posedge cache_clk) disable iff (!rst_n)
		$rose(mem_req) |-> !mem_ack)
		else report_protocol("a refill word started while mem_ack was still high");

	//======================================================================
	// Stimulus
	//======================================================================

	initial
	begin
		il1_pkg::addr_t rand_pc;
		rst_n     = 1'b0;
		fetch_req = 1'b0;
		pc        = '0;
		inv_req   = 1'b0;
		inv_addr  = '0;
		for (int s = 0; s < `IL1_SETS; s++)
		begin
			model_lru[s]      = 1'b0;
			model_valid[s][0] = 1'b0;
			model_valid[s][1] = 1'b0;
		end
		repeat (4) @(posedge cache_clk);
		#1;
		rst_n = 1'b1;
		step_cycle();

		// Cold miss, then the rest of the line from the arrays
		run_fetch(32'h0000_1234, "cold_miss");
		run_fetch(32'h0000_1230, "line_hit");
		run_fetch(32'h0000_1238, "line_hit");
		run_fetch(32'h0000_123c, "line_hit");

		// Three tags in set 5
		run_fetch(32'h0000_2050, "lru_fill_a");
		run_fetch(32'h0000_6054, "lru_fill_b");
		run_fetch(32'h0000_2058, "lru_touch_a");
		run_fetch(32'h0000_a05c, "lru_fill_c");
		run_fetch(32'h0000_2050, "lru_keep_a");
		run_fetch(32'h0000_6050, "lru_evict_b");

		run_invalidate(32'h0000_1238, "inv_resident");
		run_fetch(32'h0000_1230, "inv_refetch");
		run_invalidate(32'h0000_f0f0, "inv_absent");
		run_fetch(32'h0000_2054, "inv_absent_hit");

		// Small address space so hits, misses and evictions mix
		for (int n = 0; n < 40; n++)
		begin
			rand_pc = (32'(lfsr_bits(3)) << 8) | (32'(lfsr_bits(2)) << 4)
				| (32'(lfsr_bits(2)) << 2);
			repeat (lfsr_bits(2)) step_cycle();
			if (lfsr_bits(3) == 8'd0)
				run_invalidate(rand_pc, "random_inv");
			else
				run_fetch(rand_pc, "random_fetch");
		end

		repeat (4) step_cycle();
		$display("Summary: %0d value errors, %0d protocol errors", value_errors,
			protocol_errors);
		if (value_errors == 0 && protocol_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/il1_mem_model.sv ====
//==========================================================================
// IL1 backing memory model
// Responds to refill requests with one word per four-phase handshake,
// after random delays, with data derived from the word address
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module il1_mem_model #(
	parameter logic [31:0] SEED      = 32'h1,
	parameter logic [31:0] DATA_MULT = 32'h1
) (
	input  wire logic           cache_clk,
	input  wire logic           rst_n,
	input  wire logic           mem_req,
	input  wire il1_pkg::addr_t mem_addr,
	output logic                mem_ack,
	output il1_pkg::word_t      mem_rdata
);

	typedef enum logic [1:0] {
		MEM_IDLE,
		MEM_WAIT,
		MEM_HOLD,
		MEM_DROP
	} mem_phase_t;

	mem_phase_t  phase;
	int          delay;
	logic [31:0] lfsr_state = SEED;

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [7:0] lfsr_bits(input int n);
		logic [7:0] bits;
		logic       fb;
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			bits = {bits[6:0], fb};
		end
		return bits;
	endfunction

	// Outputs change 1 ns after the edge
	always @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			phase     <= MEM_IDLE;
			delay     <= 0;
			mem_ack   <= 1'b0;
			mem_rdata <= '0;
		end
		else
		begin
			case (phase)
				MEM_IDLE:
					if (mem_req)
					begin
						delay <= lfsr_bits(2);
						phase <= MEM_WAIT;
					end
				MEM_WAIT:
					if (delay == 0)
					begin
						mem_ack   <= #1 1'b1;
						mem_rdata <= #1 mem_addr * DATA_MULT;
						phase     <= MEM_HOLD;
					end
					else
						delay <= delay - 1;
				// Data held until the cache lets go of mem_req
				MEM_HOLD:
					if (!mem_req)
					begin
						delay <= lfsr_bits(2);
						phase <= MEM_DROP;
					end
				MEM_DROP:
					if (delay == 0)
					begin
						mem_ack <= #1 1'b0;
						phase   <= MEM_IDLE;
					end
					else
						delay <= delay - 1;
				default:
					phase <= MEM_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/il1_cache_top.sv ====
//==========================================================================
// IL1 cache top level
// 2-way instruction cache: controller with tag, data and LRU datapath
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "il1_config.svh"

module il1_cache_top (
	input  wire logic           cache_clk,
	input  wire logic           rst_n,
	// Fetch port
	input  wire logic           fetch_req,
	input  wire il1_pkg::addr_t pc,
	output logic                fetch_ack,
	output il1_pkg::word_t      inst,
	// Invalidate port
	input  wire logic           inv_req,
	input  wire il1_pkg::addr_t inv_addr,
	output logic                inv_ack,
	// Refill port
	output logic                mem_req,
	output il1_pkg::addr_t      mem_addr,
	input  wire logic           mem_ack,
	input  wire il1_pkg::word_t mem_rdata
);

	logic                 lookup_en;
	il1_pkg::index_t      lookup_index;
	il1_pkg::tag_t        lookup_tag;
	il1_pkg::offset_t     lookup_offset;
	logic                 fill_en;
	il1_pkg::way_t        fill_way;
	logic                 clear_en;
	il1_pkg::way_t        clear_way;
	logic                 hit;
	il1_pkg::way_t        hit_way;
	logic [`IL1_WAYS-1:0] set_valid;
	il1_pkg::way_t        victim_way;
	logic                 line_rd_en;
	logic                 word_we;
	il1_pkg::offset_t     word_offset;
	il1_pkg::word_t       fill_word;
	logic                 touch_en;
	il1_pkg::way_t        touch_way;

	il1_controller il1_controller_inst (
		.cache_clk     (cache_clk),
		.rst_n         (rst_n),
		.fetch_req     (fetch_req),
		.pc            (pc),
		.fetch_ack     (fetch_ack),
		.inv_req       (inv_req),
		.inv_addr      (inv_addr),
		.inv_ack       (inv_ack),
		.mem_req       (mem_req),
		.mem_addr      (mem_addr),
		.mem_ack       (mem_ack),
		.mem_rdata     (mem_rdata),
		.hit           (hit),
		.hit_way       (hit_way),
		.victim_way    (victim_way),
		.lookup_en     (lookup_en),
		.lookup_index  (lookup_index),
		.lookup_tag    (lookup_tag),
		.fill_en       (fill_en),
		.fill_way      (fill_way),
		.clear_en      (clear_en),
		.clear_way     (clear_way),
		.line_rd_en    (line_rd_en),
		.lookup_offset (lookup_offset),
		.word_we       (word_we),
		.word_offset   (word_offset),
		.fill_word     (fill_word),
		.touch_en      (touch_en),
		.touch_way     (touch_way)
	);

	il1_tag_array il1_tag_array_inst (
		.cache_clk    (cache_clk),
		.rst_n        (rst_n),
		.lookup_en    (lookup_en),
		.lookup_index (lookup_index),
		.lookup_tag   (lookup_tag),
		.fill_en      (fill_en),
		.fill_way     (fill_way),
		.clear_en     (clear_en),
		.clear_way    (clear_way),
		.hit          (hit),
		.hit_way      (hit_way),
		.set_valid    (set_valid)
	);

	// Read and refill share the set under lookup
	il1_data_array il1_data_array_inst (
		.cache_clk (cache_clk),
		.rd_en     (line_rd_en),
		.rd_index  (lookup_index),
		.rd_offset (lookup_offset),
		.wr_en     (word_we),
		.wr_way    (fill_way),
		.wr_index  (lookup_index),
		.wr_offset (word_offset),
		.wr_word   (fill_word),
		.sel_way   (hit_way),
		.inst      (inst)
	);

	il1_replace il1_replace_inst (
		.cache_clk  (cache_clk),
		.rst_n      (rst_n),
		.index      (lookup_index),
		.set_valid  (set_valid),
		.touch_en   (touch_en),
		.touch_way  (touch_way),
		.victim_way (victim_way)
	);

endmodule

`default_nettype wire

// ==== design/il1_controller.sv ====
//==========================================================================
// IL1 controller
// FSM for lookup, four-word refill, tag fill and invalidate, plus the
// fetch, invalidate and refill handshakes
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module il1_controller (
	input  wire logic             cache_clk,
	input  wire logic             rst_n,
	input  wire logic             fetch_req,
	input  wire il1_pkg::addr_t   pc,
	output logic                  fetch_ack,
	input  wire logic             inv_req,
	input  wire il1_pkg::addr_t   inv_addr,
	output logic                  inv_ack,
	output logic                  mem_req,
	output il1_pkg::addr_t        mem_addr,
	input  wire logic             mem_ack,
	input  wire il1_pkg::word_t   mem_rdata,
	input  wire logic             hit,
	input  wire il1_pkg::way_t    hit_way,
	input  wire il1_pkg::way_t    victim_way,
	// Tag array
	output logic                  lookup_en,
	output il1_pkg::index_t       lookup_index,
	output il1_pkg::tag_t         lookup_tag,
	output logic                  fill_en,
	output il1_pkg::way_t         fill_way,
	output logic                  clear_en,
	output il1_pkg::way_t         clear_way,
	// Data array
	output logic                  line_rd_en,
	output il1_pkg::offset_t      lookup_offset,
	output logic                  word_we,
	output il1_pkg::offset_t      word_offset,
	output il1_pkg::word_t        fill_word,
	// Replacement
	output logic                  touch_en,
	output il1_pkg::way_t         touch_way
);

	il1_pkg::il1_state_t state;
	il1_pkg::il1_state_t state_next;
	il1_pkg::addr_t      addr_q;
	il1_pkg::addr_t      lookup_addr;
	il1_pkg::offset_t    word_cnt;
	il1_pkg::way_t       victim_q;
	logic                tag_written;
	logic                start;

	//======================================================================
	// State machine
	//======================================================================

	always_ff @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= il1_pkg::IDLE;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = state;
		case (state)
			// Invalidate wins when both requests are up
			il1_pkg::IDLE:
				if (inv_req)
					state_next = il1_pkg::INV_LOOKUP;
				else if (fetch_req)
					state_next = il1_pkg::LOOKUP;
			il1_pkg::LOOKUP:
				state_next = hit ? il1_pkg::RESPOND : il1_pkg::REFILL_REQ;
			il1_pkg::RESPOND:
				if (!fetch_req)
					state_next = il1_pkg::IDLE;
			il1_pkg::REFILL_REQ:
				if (mem_ack)
					state_next = il1_pkg::REFILL_WAIT;
			il1_pkg::REFILL_WAIT:
				if (!mem_ack)
					state_next = (word_cnt == '1) ? il1_pkg::FILL_TAG : il1_pkg::REFILL_REQ;
			// Tag write first and a fresh read of both arrays after it
			il1_pkg::FILL_TAG:
				if (tag_written)
					state_next = il1_pkg::LOOKUP;
			il1_pkg::INV_LOOKUP:
				state_next = il1_pkg::INV_DONE;
			il1_pkg::INV_DONE:
				if (!inv_req)
					state_next = il1_pkg::IDLE;
			default:
				state_next = il1_pkg::IDLE;
		endcase
	end

	//======================================================================
	// Request and refill bookkeeping
	//======================================================================

	assign start       = (state == il1_pkg::IDLE) && (inv_req || fetch_req);
	assign lookup_addr = (state == il1_pkg::IDLE) ? (inv_req ? inv_addr : pc) : addr_q;

	always_ff @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
			addr_q <= '0;
		else if (start)
			addr_q <= lookup_addr;
	end

	always_ff @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			word_cnt    <= '0;
			victim_q    <= '0;
			tag_written <= 1'b0;
		end
		else
		begin
			// Victim fixed for the whole refill
			if (state == il1_pkg::LOOKUP && !hit)
			begin
				victim_q <= victim_way;
				word_cnt <= '0;
			end
			else if (word_we)
				word_cnt <= word_cnt + 1'b1;
			tag_written <= (state == il1_pkg::FILL_TAG) && !tag_written;
		end
	end

	// Word taken on the edge that sees mem_ack high
	always_ff @(posedge cache_clk)
	begin
		if (state == il1_pkg::REFILL_REQ && mem_ack)
			fill_word <= mem_rdata;
	end

	//======================================================================
	// Array and port controls
	//======================================================================

	assign lookup_index  = il1_pkg::addr_index(lookup_addr);
	assign lookup_tag    = il1_pkg::addr_tag(lookup_addr);
	assign lookup_offset = il1_pkg::addr_offset(lookup_addr);

	assign lookup_en  = start || (state == il1_pkg::FILL_TAG && tag_written);
	// Line reads for fetches and for the merge of each refill word
	assign line_rd_en = (start && !inv_req) || (state == il1_pkg::REFILL_REQ)
		|| (state == il1_pkg::FILL_TAG && tag_written);

	assign fill_en     = (state == il1_pkg::FILL_TAG) && !tag_written;
	assign fill_way    = victim_q;
	assign clear_en    = (state == il1_pkg::INV_LOOKUP) && hit;
	assign clear_way   = hit_way;
	assign word_we     = (state == il1_pkg::REFILL_WAIT) && !mem_ack;
	assign word_offset = word_cnt;
	assign touch_en    = ((state == il1_pkg::LOOKUP) && hit) || fill_en;
	assign touch_way   = fill_en ? victim_q : hit_way;

	assign fetch_ack = (state == il1_pkg::RESPOND);
	assign inv_ack   = (state == il1_pkg::INV_DONE);
	assign mem_req   = (state == il1_pkg::REFILL_REQ);
	assign mem_addr  = {il1_pkg::addr_tag(addr_q), il1_pkg::addr_index(addr_q), word_cnt,
		{il1_pkg::BYTE_W{1'b0}}};

	// Refill request and word address held until memory answers
	mem_req_held_a: assert property (@(posedge cache_clk) disable iff (!rst_n)
		mem_req && !mem_ack |=> mem_req && $stable(mem_addr))
		else $error("il1_controller: mem_req or mem_addr changed before mem_ack rose");

	fetch_ack_rise_a: assert property (@(posedge cache_clk) disable iff (!rst_n)
		$rose(fetch_ack) |-> $past(fetch_req))
		else $error("il1_controller: fetch_ack rose without a fetch request");

endmodule

`default_nettype wire

// ==== design/il1_replace.sv ====
//==========================================================================
// IL1 replacement
// One LRU bit per set and victim selection, invalid ways first
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "il1_config.svh"

module il1_replace (
	input  wire logic                 cache_clk,
	input  wire logic                 rst_n,
	input  wire il1_pkg::index_t      index,
	input  wire logic [`IL1_WAYS-1:0] set_valid,
	input  wire logic                 touch_en,
	input  wire il1_pkg::way_t        touch_way,
	output il1_pkg::way_t             victim_way
);

	// Each bit names the way to replace next
	logic [`IL1_SETS-1:0] lru;

	always_ff @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
			lru <= '0;
		else if (touch_en)
			lru[index] <= ~touch_way;
	end

	always_comb
	begin
		if (!set_valid[0])
			victim_way = 1'b0;
		else if (!set_valid[1])
			victim_way = 1'b1;
		else
			victim_way = lru[index];
	end

endmodule

`default_nettype wire

// ==== design/il1_data_array.sv ====
//==========================================================================
// IL1 data array
// Per-way line SRAMs with word merge on refill and word select on read
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "il1_config.svh"

module il1_data_array (
	input  wire logic             cache_clk,
	input  wire logic             rd_en,
	input  wire il1_pkg::index_t  rd_index,
	input  wire il1_pkg::offset_t rd_offset,
	input  wire logic             wr_en,
	input  wire il1_pkg::way_t    wr_way,
	input  wire il1_pkg::index_t  wr_index,
	input  wire il1_pkg::offset_t wr_offset,
	input  wire il1_pkg::word_t   wr_word,
	input  wire il1_pkg::way_t    sel_way,
	output il1_pkg::word_t        inst
);

	il1_pkg::line_t   line_rd [`IL1_WAYS];
	il1_pkg::line_t   line_wr;
	il1_pkg::offset_t off_q;

	// Old line comes from the read issued while the word was fetched
	always_comb
	begin
		line_wr = line_rd[wr_way];
		line_wr[wr_offset] = wr_word;
	end

	genvar w;
	generate
		for (w = 0; w < `IL1_WAYS; w++)
		begin : g_way
			logic line_we;

			assign line_we = wr_en && (wr_way == il1_pkg::way_t'(w));

			il1_sram #(
				.payload_t (il1_pkg::line_t),
				.DEPTH     (`IL1_SETS)
			) line_sram_inst (
				.cache_clk (cache_clk),
				.en        (rd_en || line_we),
				.we        (line_we),
				.addr      (line_we ? wr_index : rd_index),
				.wdata     (line_wr),
				.rdata     (line_rd[w])
			);
		end
	endgenerate

	// Word offset follows the line read
	always_ff @(posedge cache_clk)
	begin
		if (rd_en)
			off_q <= rd_offset;
	end

	assign inst = line_rd[sel_way][off_q];

endmodule

`default_nettype wire

// ==== design/il1_tag_array.sv ====
//==========================================================================
// IL1 tag array
// Per-way tag SRAMs, valid flops, tag compare and hit-way encode
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "il1_config.svh"

module il1_tag_array (
	input  wire logic            cache_clk,
	input  wire logic            rst_n,
	input  wire logic            lookup_en,
	input  wire il1_pkg::index_t lookup_index,
	input  wire il1_pkg::tag_t   lookup_tag,
	input  wire logic            fill_en,
	input  wire il1_pkg::way_t   fill_way,
	input  wire logic            clear_en,
	input  wire il1_pkg::way_t   clear_way,
	output logic                 hit,
	output il1_pkg::way_t        hit_way,
	output logic [`IL1_WAYS-1:0] set_valid
);

	il1_pkg::index_t                     idx_q;
	il1_pkg::tag_t                       tag_q;
	il1_pkg::tag_t                       tag_rd [`IL1_WAYS];
	logic [`IL1_SETS-1:0][`IL1_WAYS-1:0] valid;
	logic [`IL1_WAYS-1:0]                way_hit;

	// Set under lookup, also the target of fills and clears
	always_ff @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
			idx_q <= '0;
		else if (lookup_en)
			idx_q <= lookup_index;
	end

	always_ff @(posedge cache_clk)
	begin
		if (lookup_en)
			tag_q <= lookup_tag;
	end

	always_ff @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
			valid <= '0;
		else if (fill_en)
			valid[idx_q][fill_way] <= 1'b1;
		else if (clear_en)
			valid[idx_q][clear_way] <= 1'b0;
	end

	genvar w;
	generate
		for (w = 0; w < `IL1_WAYS; w++)
		begin : g_way
			logic tag_we;

			assign tag_we = fill_en && (fill_way == il1_pkg::way_t'(w));

			il1_sram #(
				.payload_t (il1_pkg::tag_t),
				.DEPTH     (`IL1_SETS)
			) tag_sram_inst (
				.cache_clk (cache_clk),
				.en        (lookup_en || tag_we),
				.we        (tag_we),
				.addr      (tag_we ? idx_q : lookup_index),
				.wdata     (tag_q),
				.rdata     (tag_rd[w])
			);

			// Valid first so an unwritten tag never hits
			assign way_hit[w] = valid[idx_q][w] && (tag_rd[w] == tag_q);
		end
	endgenerate

	always_comb
	begin
		hit_way = '0;
		for (int i = 0; i < `IL1_WAYS; i++)
			if (way_hit[i])
				hit_way = il1_pkg::way_t'(i);
	end

	assign hit       = |way_hit;
	assign set_valid = valid[idx_q];

	// A line is only ever resident in one way
	one_way_hit_a: assert property (@(posedge cache_clk) disable iff (!rst_n)
		lookup_en |=> $onehot0(way_hit))
		else $error("il1_tag_array: more than one way hits in set %0d", idx_q);

endmodule

`default_nettype wire

// ==== design/il1_sram.sv ====
//==========================================================================
// IL1 single-port SRAM
// Synchronous array with registered read data, generic payload type
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module il1_sram #(
	parameter type payload_t = logic [31:0],
	parameter int  DEPTH     = 16
) (
	input  wire logic                     cache_clk,
	input  wire logic                     en,
	input  wire logic                     we,
	input  wire logic [$clog2(DEPTH)-1:0] addr,
	input  wire payload_t                 wdata,
	output payload_t                      rdata
);

	payload_t mem [DEPTH];

	// One access per cycle, write or read
	always_ff @(posedge cache_clk)
	begin
		if (en)
		begin
			if (we)
				mem[addr] <= wdata;
			else
				rdata <= mem[addr];
		end
	end

	//======================================================================
	// Checks
	//======================================================================

	addr_known_a: assert property (@(posedge cache_clk) en |-> !$isunknown(addr))
		else $error("il1_sram: address has unknown bits on an enabled access");

endmodule

`default_nettype wire

// ==== design/il1_pkg.sv ====
//==========================================================================
// IL1 shared types
// Address fields, storage payloads and controller states
//==========================================================================

`default_nettype none

`include "il1_config.svh"

package il1_pkg;

	localparam int OFFSET_W = $clog2(`IL1_WORDS);
	localparam int INDEX_W  = $clog2(`IL1_SETS);
	localparam int BYTE_W   = $clog2(`IL1_WORD_W / 8);
	localparam int TAG_W    = `IL1_ADDR_W - INDEX_W - OFFSET_W - BYTE_W;

	typedef logic [`IL1_WORD_W-1:0]       word_t;
	typedef logic [`IL1_ADDR_W-1:0]       addr_t;
	typedef logic [INDEX_W-1:0]           index_t;
	typedef logic [OFFSET_W-1:0]          offset_t;
	typedef logic [TAG_W-1:0]             tag_t;
	typedef word_t [`IL1_WORDS-1:0]       line_t;
	typedef logic [$clog2(`IL1_WAYS)-1:0] way_t;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		RESPOND,
		REFILL_REQ,
		REFILL_WAIT,
		FILL_TAG,
		INV_LOOKUP,
		INV_DONE
	} il1_state_t;

	// Address split: tag | index | word | byte
	function automatic index_t addr_index(input addr_t a);
		return a[BYTE_W+OFFSET_W +: INDEX_W];
	endfunction

	function automatic offset_t addr_offset(input addr_t a);
		return a[BYTE_W +: OFFSET_W];
	endfunction

	function automatic tag_t addr_tag(input addr_t a);
		return a[`IL1_ADDR_W-1 -: TAG_W];
	endfunction

endpackage

`default_nettype wire

// ==== design/il1_config.svh ====
//==========================================================================
// IL1 cache configuration
// Geometry and width macros for the level-1 instruction cache
//==========================================================================

`ifndef IL1_CONFIG_SVH
`define IL1_CONFIG_SVH

// Two ways, tied to the single LRU bit per set
`define IL1_WAYS 2

// Sets in each way
`define IL1_SETS 16

// Instruction words per cache line
`define IL1_WORDS 4

// Byte address width
`define IL1_ADDR_W 32

// Instruction word width
`define IL1_WORD_W 32

`endif
